// ==== design/riscv_isa_pkg.sv ====
// RV64 instruction set definitions
`default_nettype none

package riscv_isa_pkg;

    // field widths
    localparam int XLEN      = 64;  // integer register width
    localparam int ILEN      = 32;  // base encoding only, no compressed
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int FUNCT7_W  = 7;

    typedef logic [XLEN-1:0]      xlen_t;     // register and data value
    typedef logic [XLEN-1:0]      addr_t;     // instruction address
    typedef logic [ILEN-1:0]      instr_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;  // x0..x31
    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [FUNCT3_W-1:0]  funct3_t;
    typedef logic [FUNCT7_W-1:0]  funct7_t;

    // major opcodes, instr[6:0]
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_IMM    = 7'b0010011;  // addi and friends
    localparam opcode_t OP_REG    = 7'b0110011;  // add, sub, ...
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // minor selectors
    localparam funct3_t F3_ADD = 3'b000;  // shared by addi, add and sub
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct7_t F7_SUB = 7'b0100000;

    // addi x0, x0, 0
    localparam instr_t INSTR_NOP = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== design/core_pipe_pkg.sv ====
// Core pipeline stage types
`default_nettype none

package core_pipe_pkg;

    import riscv_isa_pkg::*;

    // one fetched word and where it came from
    typedef struct packed {
        instr_t instr;
        addr_t  pc;
    } fetch_entry_t;

    // change of flow from execute, one cycle wide
    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

    // what a retiring instruction did
    typedef struct packed {
        addr_t    pc;
        reg_idx_t rd;
        logic     we;     // low for branches, x0 and unknown opcodes
        xlen_t    value;
    } retire_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,       // waiting for queue space
        FETCH_REQ,        // req high, waiting for ack
        FETCH_RELEASE     // req low, waiting for ack to drop
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
// Instruction fetch with four-phase memory port
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import riscv_isa_pkg::*;
    import core_pipe_pkg::*;
#(
    parameter addr_t RESET_PC = '0
) (
    input  logic         clk_1hz,
    input  logic         reset_n,
    output logic         imem_req,
    output addr_t        imem_addr,
    input  logic         imem_ack,
    input  instr_t       imem_rdata,
    output logic         push_valid,
    output fetch_entry_t push_entry,
    input  logic         push_ready,
    input  redirect_t    redirect
);

    fetch_state_t state;
    addr_t        pc;         // next address to fetch
    logic         discard;    // in-flight word belongs to the old path
    logic         capture;

    assign imem_req = (state == FETCH_REQ);   // straight from the state flop
    assign capture  = (state == FETCH_REQ) && imem_ack;

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            state      <= FETCH_IDLE;
            pc         <= RESET_PC;
            imem_addr  <= RESET_PC;
            discard    <= 1'b0;
            push_valid <= 1'b0;
        end else begin
            // queue took it, or the flush threw it away
            if (push_valid && (push_ready || redirect.taken)) begin
                push_valid <= 1'b0;
            end
            if (redirect.taken) begin
                pc <= redirect.target;
            end

            case (state)
                FETCH_IDLE: begin
                    // one word outstanding at most, so no overwrite of push_entry
                    if (push_ready && !push_valid) begin
                        imem_addr <= redirect.taken ? redirect.target : pc;
                        state     <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    if (imem_ack) begin
                        state   <= FETCH_RELEASE;
                        discard <= 1'b0;
                        if (!redirect.taken && !discard) begin
                            push_valid <= 1'b1;     // pushed next cycle
                            pc         <= pc + 64'd4;
                        end
                    end else if (redirect.taken) begin
                        discard <= 1'b1;  // finish the handshake, drop the word
                    end
                end
                FETCH_RELEASE: begin
                    if (!imem_ack) begin
                        state <= FETCH_IDLE;  // new req only after ack seen low
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // payload, qualified by push_valid
    always_ff @(posedge clk_1hz) begin
        if (capture) begin
            push_entry <= '{instr: imem_rdata, pc: imem_addr};
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_queue.sv ====
// Flushable instruction queue
`timescale 1ns/1ps
`default_nettype none

module fetch_queue
    import core_pipe_pkg::*;
#(
    parameter int QUEUE_DEPTH = 2   // power of two, 2 or more
) (
    input  logic         clk_1hz,
    input  logic         reset_n,
    input  logic         push_valid,
    input  fetch_entry_t push_entry,
    output logic         push_ready,
    output logic         head_valid,
    output fetch_entry_t head_entry,
    input  logic         pop,
    input  logic         flush
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;   // room for the full count

    fetch_entry_t     mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign push_ready = (count != CNT_W'(QUEUE_DEPTH));
    assign head_valid = (count != '0);
    assign head_entry = mem[rd_ptr];     // show-ahead head

    // flush beats a push in the same cycle
    assign do_push = push_valid && push_ready && !flush;
    assign do_pop  = pop && head_valid && !flush;

    always_ff @(posedge clk_1hz) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;   // drop everything on redirect
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is 2^n
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none, or both at once
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
// Decode, execute and retire
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import riscv_isa_pkg::*;
    import core_pipe_pkg::*;
(
    input  logic         clk_1hz,
    input  logic         reset_n,
    input  logic         head_valid,
    input  fetch_entry_t head_entry,
    output logic         pop,
    output redirect_t    redirect,
    output logic         retire_valid,
    output retire_t      retire
);

    xlen_t    rf [32];   // x0 kept at zero, never written
    instr_t   instr;
    addr_t    pc;
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    funct3_t  funct3;
    funct7_t  funct7;
    xlen_t    imm_i;
    xlen_t    imm_u;
    xlen_t    imm_j;
    xlen_t    imm_b;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    result;
    addr_t    target;
    logic     wr_en;
    logic     rd_write;
    logic     taken;
    logic     issue;

    assign instr  = head_entry.instr;
    assign pc     = head_entry.pc;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // sign-extended immediates
    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];   // x0 reads as zero
    assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

    // every head word is consumed; the one behind a taken redirect is a bubble
    assign pop   = head_valid;
    assign issue = head_valid && !redirect.taken;

    always_comb begin
        result = '0;
        wr_en  = 1'b0;
        taken  = 1'b0;
        target = pc + imm_b;
        case (opcode)
            OP_LUI: begin
                wr_en  = 1'b1;
                result = imm_u;
            end
            OP_AUIPC: begin
                wr_en  = 1'b1;
                result = pc + imm_u;
            end
            OP_IMM: begin
                wr_en  = (funct3 == F3_ADD);   // addi only
                result = rs1_val + imm_i;
            end
            OP_REG: begin
                if (funct3 == F3_ADD && funct7 == F7_SUB) begin
                    wr_en  = 1'b1;
                    result = rs1_val - rs2_val;
                end else if (funct3 == F3_ADD && funct7 == '0) begin
                    wr_en  = 1'b1;
                    result = rs1_val + rs2_val;
                end
            end
            OP_JAL: begin
                wr_en  = 1'b1;
                result = pc + 64'd4;   // link value
                taken  = 1'b1;
                target = pc + imm_j;
            end
            OP_BRANCH: begin
                if (funct3 == F3_BEQ) taken = (rs1_val == rs2_val);
                if (funct3 == F3_BNE) taken = (rs1_val != rs2_val);
            end
            default: ;   // retires with no effect
        endcase
    end

    assign rd_write = wr_en && (rd != '0);

    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            retire_valid <= 1'b0;
            redirect     <= '0;
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;   // registers start cleared
            end
        end else begin
            retire_valid    <= issue;
            redirect.taken  <= issue && taken;   // one cycle, flushes queue
            redirect.target <= target;
            if (issue && rd_write) begin
                rf[rd] <= result;
            end
        end
    end

    always_ff @(posedge clk_1hz) begin
        if (issue) begin
            retire <= '{pc: pc, rd: rd, we: rd_write, value: result};
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_core_top.sv ====
// RV64 two-stage core
`timescale 1ns/1ps
`default_nettype none

module rv_core_top
    import riscv_isa_pkg::*;
    import core_pipe_pkg::*;
#(
    parameter addr_t RESET_PC    = '0,
    parameter int    QUEUE_DEPTH = 2
) (
    input  logic    clk_1hz,
    input  logic    reset_n,
    output logic    imem_req,
    output addr_t   imem_addr,
    input  logic    imem_ack,
    input  instr_t  imem_rdata,
    output logic    retire_valid,
    output retire_t retire
);

    logic         push_valid;
    logic         push_ready;
    fetch_entry_t push_entry;
    logic         head_valid;
    fetch_entry_t head_entry;
    logic         pop;
    redirect_t    redirect;   // back to fetch and queue

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_1hz    (clk_1hz),
        .reset_n    (reset_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .push_valid (push_valid),
        .push_entry (push_entry),
        .push_ready (push_ready),
        .redirect   (redirect)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk_1hz    (clk_1hz),
        .reset_n    (reset_n),
        .push_valid (push_valid),
        .push_entry (push_entry),
        .push_ready (push_ready),
        .head_valid (head_valid),
        .head_entry (head_entry),
        .pop        (pop),
        .flush      (redirect.taken)
    );

    exec_unit u_exec (
        .clk_1hz      (clk_1hz),
        .reset_n      (reset_n),
        .head_valid   (head_valid),
        .head_entry   (head_entry),
        .pop          (pop),
        .redirect     (redirect),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// ==== testbench/rv_core_assert.sv ====
// Instruction port protocol checks
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert
    import riscv_isa_pkg::*;
(
    input logic  clk_1hz,
    input logic  reset_n,
    input logic  imem_req,
    input logic  imem_ack,
    input addr_t imem_addr,
    input logic  retire_valid
);

    int unsigned fail_count = 0;   // tally of failed properties

    // request held until the memory answers
    req_held_until_ack: assert property (
        @(posedge clk_1hz) disable iff (!reset_n)
        (imem_req && !imem_ack) |=> imem_req
    ) else begin
        $error("imem_req dropped before imem_ack was seen");
        fail_count++;
    end

    // a new request waits for ack low
    req_rise_needs_ack_low: assert property (
        @(posedge clk_1hz) disable iff (!reset_n)
        $rose(imem_req) |-> !imem_ack
    ) else begin
        $error("imem_req rose while imem_ack was still high");
        fail_count++;
    end

    assert property (
        @(posedge clk_1hz) disable iff (!reset_n)
        (imem_req && $past(imem_req)) |-> $stable(imem_addr)   // addr frozen during req
    ) else begin
        $error("imem_addr changed while imem_req was high");
        fail_count++;
    end

    // nothing retires straight out of reset
    quiet_after_reset: assert property (
        @(posedge clk_1hz) $rose(reset_n) |-> !retire_valid
    ) else begin
        $error("retire_valid high in the first cycle after reset");
        fail_count++;
    end

endmodule

bind rv_core_top rv_core_assert u_assert (
    .clk_1hz      (clk_1hz),
    .reset_n      (reset_n),
    .imem_req     (imem_req),
    .imem_ack     (imem_ack),
    .imem_addr    (imem_addr),
    .retire_valid (retire_valid)
);

`default_nettype wire

// ==== testbench/tb_rv_core.sv ====
// RV64 core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import riscv_isa_pkg::*;
    import core_pipe_pkg::*;
();

    localparam int MEM_WORDS   = 64;
    localparam int TOTAL_INSTR = 63;                  // 8 + 10 + 8 + 12 + 25 words
    localparam int CYCLE_LIMIT = 200 * TOTAL_INSTR;

    logic    clk_1hz;
    logic    reset_n;
    logic    imem_req;
    addr_t   imem_addr;
    logic    imem_ack   = 1'b0;
    instr_t  imem_rdata = INSTR_NOP;
    logic    retire_valid;
    retire_t retire;

    instr_t  prog_mem [MEM_WORDS];   // instruction memory behind the port
    instr_t  prog [$];               // program under construction
    retire_t expected [$];
    retire_t observed [$];
    int      max_delay   = 0;        // longest ack wait, in cycles
    int      wait_left   = -1;       // -1 when no wait is armed
    int      cycle_count = 0;
    int      checks      = 0;
    int      errors      = 0;

    rv_core_top #(
        .RESET_PC    (64'd0),
        .QUEUE_DEPTH (2)
    ) u_dut (
        .clk_1hz      (clk_1hz),
        .reset_n      (reset_n),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_ack     (imem_ack),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk_1hz = 1'b0;
        forever #20 clk_1hz = ~clk_1hz;   // 40 ns period
    end

    // four-phase responder, one ack edge per owed phase
    always @(posedge clk_1hz) begin
        if (!reset_n) begin
            imem_ack  <= 1'b0;
            wait_left = -1;
        end else if (imem_req != imem_ack) begin
            if (wait_left < 0) begin
                wait_left = int'($urandom_range(3, 0)) % (max_delay + 1);
            end
            if (wait_left == 0) begin
                imem_ack <= imem_req;   // raise on req high, drop on req low
                if (imem_req) imem_rdata <= prog_mem[imem_addr[7:2]];
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(posedge clk_1hz) begin
        if (reset_n && retire_valid) observed.push_back(retire);   // retire monitor
    end

    always @(posedge clk_1hz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the core stopped retiring", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    // instruction encoders
    function automatic instr_t upper_imm(opcode_t op, int rd, int imm);
        return {20'(imm), 5'(rd), op};
    endfunction

    function automatic instr_t addi(int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), F3_ADD, 5'(rd), OP_IMM};
    endfunction

    function automatic instr_t alu_rr(funct7_t f7, int rd, int rs1, int rs2);
        return {f7, 5'(rs2), 5'(rs1), F3_ADD, 5'(rd), OP_REG};
    endfunction

    function automatic instr_t jal(int rd, int offset);
        logic [20:0] off;
        off = 21'(offset);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), OP_JAL};
    endfunction

    function automatic instr_t branch(funct3_t f3, int rs1, int rs2, int offset);
        logic [12:0] off;
        off = 13'(offset);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    // ISA model, walks prog_mem up to the first self-loop jal
    task automatic build_expected();
        xlen_t   x [32];
        addr_t   pc;
        addr_t   next_pc;
        instr_t  w;
        xlen_t   imm;
        retire_t r;
        bit      done;
        int      steps;
        expected.delete();
        foreach (x[i]) x[i] = '0;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            w       = prog_mem[pc[7:2]];
            r.pc    = pc;
            r.rd    = w[11:7];
            r.we    = 1'b0;
            r.value = '0;
            next_pc = pc + 64'd4;
            case (w[6:0])
                OP_LUI: begin
                    r.we    = 1'b1;
                    r.value = {{32{w[31]}}, w[31:12], 12'h000};
                end
                OP_AUIPC: begin
                    r.we    = 1'b1;
                    r.value = pc + {{32{w[31]}}, w[31:12], 12'h000};
                end
                OP_IMM: begin
                    r.we    = (w[14:12] == F3_ADD);
                    r.value = x[w[19:15]] + {{52{w[31]}}, w[31:20]};
                end
                OP_REG: begin
                    if (w[14:12] == F3_ADD && w[31:25] == 7'd0) begin
                        r.we    = 1'b1;
                        r.value = x[w[19:15]] + x[w[24:20]];
                    end else if (w[14:12] == F3_ADD && w[31:25] == F7_SUB) begin
                        r.we    = 1'b1;
                        r.value = x[w[19:15]] - x[w[24:20]];
                    end
                end
                OP_JAL: begin
                    r.we    = 1'b1;
                    r.value = pc + 64'd4;   // link
                    imm     = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                    next_pc = pc + imm;
                    done    = (imm == '0);
                end
                OP_BRANCH: begin
                    imm = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                    if (w[14:12] == F3_BEQ && x[w[19:15]] == x[w[24:20]]) next_pc = pc + imm;
                    if (w[14:12] == F3_BNE && x[w[19:15]] != x[w[24:20]]) next_pc = pc + imm;
                end
                default: ;
            endcase
            if (r.rd == '0) r.we = 1'b0;   // x0 stays zero
            if (r.we) x[r.rd] = r.value;
            expected.push_back(r);
            pc    = next_pc;
            steps = steps + 1;
        end
    endtask

    task automatic check_value(string name, string what, int idx, xlen_t exp, xlen_t act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("ERROR %s retire %0d %s expected %h actual %h", name, idx, what, exp, act);
        end
    endtask

    // load, reset, collect retires and compare in order
    task automatic run_program(string name, int delay_max);
        reset_n <= 1'b0;
        @(posedge clk_1hz);
        max_delay = delay_max;
        foreach (prog_mem[i]) prog_mem[i] = addi(0, 0, i);   // filler tagged by address
        foreach (prog[i]) prog_mem[i] = prog[i];
        prog.delete();
        build_expected();
        repeat (2) @(posedge clk_1hz);
        reset_n <= 1'b1;
        observed.delete();
        while (observed.size() < expected.size()) @(posedge clk_1hz);
        for (int i = 0; i < expected.size(); i++) begin
            check_value(name, "pc", i, expected[i].pc, observed[i].pc);
            check_value(name, "rd", i, xlen_t'(expected[i].rd), xlen_t'(observed[i].rd));
            check_value(name, "we", i, xlen_t'(expected[i].we), xlen_t'(observed[i].we));
            if (expected[i].we) check_value(name, "value", i, expected[i].value,
                                            observed[i].value);
        end
        @(posedge clk_1hz);
    endtask

    task automatic upper_imm_ops();
        prog.push_back(upper_imm(OP_LUI, 1, 'h12345));
        prog.push_back(upper_imm(OP_LUI, 2, 'hfffff));     // negative upper
        prog.push_back(upper_imm(OP_AUIPC, 3, 'h00001));
        prog.push_back(upper_imm(OP_AUIPC, 4, 'h80000));
        prog.push_back(addi(5, 1, 'h7ff));
        prog.push_back(addi(6, 0, -1));
        prog.push_back(addi(7, 2, -16));
        prog.push_back(jal(0, 0));
        run_program("upper_imm_ops", 0);
    endtask

    task automatic add_sub_chain();
        prog.push_back(addi(1, 0, 100));
        prog.push_back(addi(2, 0, -7));
        prog.push_back(alu_rr(7'd0, 3, 1, 2));
        prog.push_back(alu_rr(F7_SUB, 4, 2, 1));
        prog.push_back(alu_rr(7'd0, 0, 1, 1));   // dropped write
        prog.push_back(addi(0, 0, 55));
        prog.push_back(alu_rr(7'd0, 5, 0, 3));   // x0 reads back zero
        prog.push_back(alu_rr(F7_SUB, 6, 0, 1));
        prog.push_back(alu_rr(F7_SUB, 7, 3, 3));
        prog.push_back(jal(0, 0));
        run_program("add_sub_chain", 0);
    endtask

    task automatic jal_skips();
        prog.push_back(addi(1, 0, 5));
        prog.push_back(jal(2, 16));
        prog.push_back(addi(3, 1, 1));            // reached backwards
        prog.push_back(jal(0, 16));
        prog.push_back(addi(1, 0, 99));           // never retires
        prog.push_back(addi(1, 1, 2));
        prog.push_back(jal(4, -16));
        prog.push_back(jal(0, 0));
        run_program("jal_skips", 0);
    endtask

    task automatic branch_outcomes();
        prog.push_back(addi(1, 0, 3));
        prog.push_back(addi(2, 0, 3));
        prog.push_back(addi(3, 0, -2));
        prog.push_back(branch(F3_BEQ, 1, 2, 8));  // taken
        prog.push_back(addi(10, 0, 1));
        prog.push_back(branch(F3_BNE, 1, 2, 8));  // falls through
        prog.push_back(branch(F3_BEQ, 1, 3, 8));
        prog.push_back(branch(F3_BNE, 1, 3, 8));
        prog.push_back(addi(10, 0, 2));
        prog.push_back(addi(3, 3, 1));
        prog.push_back(branch(F3_BNE, 3, 0, -4)); // loop until x3 hits zero
        prog.push_back(jal(0, 0));
        run_program("branch_outcomes", 0);
    endtask

    task automatic random_delay_program();
        int kind;
        int rd;
        int rs1;
        int rs2;
        for (int i = 0; i < 24; i++) begin
            kind = int'($urandom_range(7, 0));
            rd   = int'($urandom_range(7, 0));
            rs1  = int'($urandom_range(7, 0));
            rs2  = int'($urandom_range(7, 0));
            if (i == 23 && kind >= 5) kind = 2;   // last slot must fall into the loop
            case (kind)
                0: prog.push_back(upper_imm(OP_LUI, rd, int'($urandom)));
                1: prog.push_back(upper_imm(OP_AUIPC, rd, int'($urandom)));
                2: prog.push_back(addi(rd, rs1, int'($urandom_range(4095, 0))));
                3: prog.push_back(alu_rr(7'd0, rd, rs1, rs2));
                4: prog.push_back(alu_rr(F7_SUB, rd, rs1, rs2));
                5: prog.push_back(branch(F3_BEQ, rs1, rs2, 8));
                6: prog.push_back(branch(F3_BNE, rs1, rs2, 8));
                default: prog.push_back(jal(rd, 8));
            endcase
        end
        prog.push_back(jal(0, 0));
        run_program("random_delay_program", 3);
    endtask

    initial begin
        void'($urandom(32'hb118_4ed9));
        reset_n = 1'b0;
        upper_imm_ops();
        add_sub_chain();
        jal_skips();
        branch_outcomes();
        random_delay_program();
        errors = errors + int'(u_dut.u_assert.fail_count);
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 u_dut.u_assert.fail_count);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/riscv_isa_pkg.sv
design/core_pipe_pkg.sv
design/fetch_unit.sv
design/fetch_queue.sv
design/exec_unit.sv
design/rv_core_top.sv
testbench/rv_core_assert.sv
testbench/tb_rv_core.sv

// ==== Makefile ====
TOP := tb_rv_core
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f $(wildcard design/*.sv testbench/*.sv)
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
